// File: sim.f
hw/lsu_pkg.sv
hw/lsu_req_format.sv
hw/lsu_bus_issue.sv
hw/lsu_resp_align.sv
hw/lsu_top.sv
tb/lsu_clk_gen.sv
tb/lsu_mem_model.sv
tb/lsu_tb.sv

// File: tb/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int unsigned n_access   = 200;
  localparam int unsigned max_cycles = n_access * 8 + 100;

  logic clk, rst_n, ex_valid, data_req, gnt, rvalid, ready_ex, ready_wb, busy;
  lsu_ex_req_t  ex_req;
  lsu_bus_req_t data_bus;
  logic [31:0] mem_rdata, rdata;
  logic [31:0] exp_addr, exp_wdata;  // expected address phase driven with the access
  logic [3:0]  exp_be;
  logic        outst_ref, pend_load;  // transfer owed by the bus
  logic [31:0] pend_exp;
  logic [32:0] head;
  logic [32:0] exp_q[$];              // {is_load, value} per access in issue order
  logic [31:0] ref_mem [16];          // testbench copy of the memory
  int err_cnt = 0, err_mark = 0, test_num = 0, test_fail = 0;
  int chk_cnt = 0, grant_cnt = 0, rsp_cnt = 0, cycles = 0;

  lsu_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top UUT (
    .clk(clk), .rst_n(rst_n), .ex_valid_i(ex_valid), .ex_req_i(ex_req),
    .lsu_ready_ex_o(ready_ex), .lsu_ready_wb_o(ready_wb), .busy_o(busy),
    .data_req_o(data_req), .data_bus_o(data_bus), .data_gnt_i(gnt),
    .data_rvalid_i(rvalid), .data_rdata_i(mem_rdata), .rdata_o(rdata)
  );

  lsu_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(data_req), .bus_i(data_bus),
    .gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(mem_rdata)
  );

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  function automatic logic [3:0] lanes_for(input lsu_dtype_e dt, input logic [1:0] off);
    if (dt == LSU_WORD) return 4'b1111;
    return (dt == LSU_HALF ? 4'b0011 : 4'b0001) << off;  // aligned lane pair or lane
  endfunction

  function automatic logic [31:0] rotate_store(input logic [31:0] w, input logic [1:0] rot);
    logic [63:0] dbl;
    dbl = {w, w} << (8 * rot);  // top half is w rotated left
    return dbl[63:32];
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] word, input lsu_dtype_e dt,
                                             input lsu_ext_e ext, input logic [1:0] off);
    logic [31:0] sh;
    logic [31:0] keep;
    logic        top;
    sh   = word >> (8 * off);
    keep = (dt == LSU_HALF) ? 32'h0000_ffff : 32'h0000_00ff;
    top  = (dt == LSU_HALF) ? sh[15] : sh[7];
    if (dt == LSU_WORD) return word;
    if (ext == LSU_EXT_ONES || (ext == LSU_EXT_SIGN && top)) return (sh & keep) | ~keep;
    return sh & keep;
  endfunction

  function automatic logic [31:0] aligned_addr(input logic [31:0] base, input lsu_dtype_e dt);
    logic [1:0] off;
    off = 2'($urandom_range(3, 0));
    if (dt == LSU_WORD) off = 2'b00;
    else if (dt == LSU_HALF) off[0] = 1'b0;
    return {base[31:2], off};
  endfunction

  function automatic lsu_ex_req_t make_req(input logic we, input lsu_dtype_e dt,
                                           input lsu_ext_e ext, input logic [31:0] addr,
                                           input logic incr);
    lsu_ex_req_t rq;
    rq.op_b       = $urandom();  // random even when unused
    rq.op_a       = incr ? addr - rq.op_b : addr;
    rq.use_incr   = incr;
    rq.we         = we;
    rq.dtype      = dt;
    rq.ext        = ext;
    rq.wdata      = $urandom();
    rq.reg_offset = 2'($urandom_range(3, 0));
    return rq;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    err_cnt++;
    $display("ERROR %s: got 0x%h, expected 0x%h", sig, got, exp);
  endtask

  task automatic report_fail(input string what);
    err_cnt++;
    $display("ERROR %s", what);
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (err_cnt != err_mark) test_fail++;
    $display("test %0d %-22s %0d errors", test_num, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // drive one access and wait until the LSU takes it
  task automatic do_access(input lsu_ex_req_t rq, input logic [31:0] addr, input bit gaps);
    logic [3:0]  be;
    logic [31:0] wd;
    int          idx;
    int          n;
    idx = addr[5:2];
    be  = lanes_for(rq.dtype, addr[1:0]);
    wd  = rotate_store(rq.wdata, addr[1:0] - rq.reg_offset);
    if (rq.we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) ref_mem[idx][8*b +: 8] = wd[8*b +: 8];  // enabled lanes only
      end
      exp_q.push_back({1'b0, 32'h0});
    end else begin
      exp_q.push_back({1'b1, load_value(ref_mem[idx], rq.dtype, rq.ext, addr[1:0])});
    end
    ex_req    <= rq;
    ex_valid  <= 1'b1;
    exp_addr  <= addr;
    exp_be    <= be;
    exp_wdata <= wd;
    do @(posedge clk); while (!ready_ex);
    n = gaps ? $urandom_range(1, 0) : 0;
    if (n != 0) begin
      ex_valid <= 1'b0;  // idle cycle between accesses
      repeat (n) @(posedge clk);
    end
  endtask

  // load, store into the same word, then reload in all three fill modes
  task automatic run_groups(input int n, input int mode, input bit gaps);
    lsu_dtype_e  ld_dt;
    lsu_dtype_e  st_dt;
    logic [31:0] ld_addr;
    logic [31:0] st_addr;
    logic        incr;
    for (int g = 0; g < n; g++) begin
      ld_dt   = lsu_dtype_e'($urandom_range(2, 0));
      st_dt   = lsu_dtype_e'($urandom_range(2, 0));
      ld_addr = aligned_addr($urandom(), ld_dt);
      st_addr = aligned_addr(ld_addr, st_dt);
      incr    = (mode == 2) ? 1'($urandom_range(1, 0)) : 1'(mode);
      do_access(make_req(1'b0, ld_dt, lsu_ext_e'($urandom_range(2, 0)), ld_addr, incr),
                ld_addr, gaps);
      do_access(make_req(1'b1, st_dt, LSU_EXT_ZERO, st_addr, incr), st_addr, gaps);
      for (int e = 0; e < 3; e++) begin
        do_access(make_req(1'b0, ld_dt, lsu_ext_e'(e), ld_addr, incr), ld_addr, gaps);
      end
    end
  endtask

  initial begin
    int unsigned seed_ret;
    seed_ret = $urandom(32'h6db9_1192);
    ex_valid = 1'b0;
    ex_req = '0;
    exp_addr = '0;
    exp_be = '0;
    exp_wdata = '0;
    for (int i = 0; i < 16; i++) ref_mem[i] = (i * 32'h0101_0101) ^ 32'h5ac3_3c5a;
    do @(posedge clk); while (!rst_n);
    repeat (3) @(posedge clk);  // idle after reset
    finish_test("reset and idle");
    run_groups(13, 0, 1'b1);
    finish_test("base address");
    run_groups(13, 1, 1'b1);
    finish_test("incremented address");
    run_groups(14, 2, 1'b0);
    ex_valid <= 1'b0;
    do @(posedge clk); while (busy);
    @(posedge clk);
    if (grant_cnt != n_access || rsp_cnt != grant_cnt) report_fail("accesses or responses lost");
    finish_test("back to back mixed");
    $display("%0d tests, %0d failing, %0d errors, %0d load results checked",
             test_num, test_fail, err_cnt, chk_cnt);
    if (err_cnt == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // bus tracking and checks
  ////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_ref <= 1'b0;
      pend_load <= 1'b0;
      pend_exp  <= '0;
    end else begin
      if (rvalid) begin
        rsp_cnt++;
        if (pend_load) chk_cnt++;
      end
      if (data_req && gnt) begin
        grant_cnt++;
        outst_ref <= 1'b1;  // same-cycle response leaves it set
        if (exp_q.size() == 0) report_fail("grant without a queued access");
        else begin
          head = exp_q.pop_front();
          pend_load <= head[32];
          pend_exp  <= head[31:0];
        end
      end else if (rvalid) outst_ref <= 1'b0;
    end
  end

  a_reset: assert property (@(posedge clk) !rst_n |-> !data_req && !busy)
    else report_fail("request or busy high during reset");
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_valid && !outst_ref |-> !data_req && !busy)
    else report_fail("request or busy high with nothing in flight");
  a_busy: assert property (@(posedge clk) disable iff (!rst_n) ex_valid || outst_ref |-> busy)
    else report_fail("busy_o low with an access requested or in flight");
  a_ready: assert property (@(posedge clk) disable iff (!rst_n) !ex_valid |-> ready_ex)
    else report_fail("lsu_ready_ex_o low without a valid access");
  a_addr: assert property (@(posedge clk) disable iff (!rst_n)
    data_req && gnt |-> data_bus.addr == exp_addr)
    else report_mismatch("data_bus_o.addr", $sampled(data_bus.addr), $sampled(exp_addr));
  a_be: assert property (@(posedge clk) disable iff (!rst_n)
    data_req && gnt && data_bus.we |-> data_bus.be == exp_be)
    else report_mismatch("data_bus_o.be", 32'($sampled(data_bus.be)), 32'($sampled(exp_be)));
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    data_req && gnt && data_bus.we |-> data_bus.wdata == exp_wdata)
    else report_mismatch("data_bus_o.wdata", $sampled(data_bus.wdata), $sampled(exp_wdata));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && pend_load |-> rdata == pend_exp)
    else report_mismatch("rdata_o", $sampled(rdata), $sampled(pend_exp));
  a_gate: assert property (@(posedge clk) disable iff (!rst_n) outst_ref && !rvalid |-> !data_req)
    else report_fail("request raised while a response was still due");
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_req && !gnt |=> data_req && $stable(data_bus))
    else report_fail("request dropped or data_bus_o changed before its grant");
  a_stall: assert property (@(posedge clk) disable iff (!rst_n) data_req && !gnt |-> !ready_ex)
    else report_fail("lsu_ready_ex_o high while the request waits for grant");
  a_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ready_wb == (outst_ref ? rvalid : 1'b1))
    else report_mismatch("lsu_ready_wb_o", 32'($sampled(ready_wb)),
                         $sampled(outst_ref) ? 32'($sampled(rvalid)) : 32'h1);

  // run limit from the access count
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, run stopped", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

// File: tb/lsu_mem_model.sv
`timescale 1ns/1ps

module lsu_mem_model import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  input  lsu_bus_req_t          bus_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [lsu_data_w-1:0] rdata_o
);

  logic [lsu_data_w-1:0] mem [16];  // 16 words, aliased over the whole space
  logic [1:0]            gnt_wait;  // cycles left before the next grant
  logic                  rsp_pend;  // response scheduled but not yet sent
  logic [1:0]            rsp_wait;
  logic [lsu_data_w-1:0] rsp_data;
  logic [lsu_data_w-1:0] rd;
  int unsigned           dly;

  assign gnt_o = req_i & (gnt_wait == 2'd0);  // zero wait grants in the request cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] <= (i * 32'h0101_0101) ^ 32'h5ac3_3c5a;  // fill depends on the word index
      end
      gnt_wait <= 2'd0;
      rsp_pend <= 1'b0;
      rsp_wait <= 2'd0;
      rsp_data <= '0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= 1'b0;
      if (rsp_pend) begin
        if (rsp_wait == 2'd0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= rsp_data;
          rsp_pend <= 1'b0;
        end else begin
          rsp_wait <= rsp_wait - 2'd1;
        end
      end
      if (req_i && !gnt_o) gnt_wait <= gnt_wait - 2'd1;  // request waits, count down
      if (gnt_o) begin
        gnt_wait <= 2'($urandom_range(2, 0));  // delay for the next request
        rd = bus_i.we ? '0 : mem[bus_i.addr[5:2]];
        for (int b = 0; b < 4; b++) begin
          if (bus_i.we && bus_i.be[b]) mem[bus_i.addr[5:2]][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
        dly = $urandom_range(3, 1);  // response 1 to 3 cycles after the grant
        if (dly == 1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= rd;
        end else begin
          rsp_pend <= 1'b1;
          rsp_wait <= 2'(dly - 2);
          rsp_data <= rd;
        end
      end
    end
  end

endmodule

// File: tb/lsu_clk_gen.sv
`timescale 1ns/1ps

module lsu_clk_gen (
  output logic clk_o,   // 20 ns period
  output logic rst_n_o  // low for the first 8 cycles
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;  // release on a rising edge
  end

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // EX side
  input  logic                  ex_valid_i,
  input  lsu_ex_req_t           ex_req_i,
  output logic                  lsu_ready_ex_o,
  output logic                  lsu_ready_wb_o,
  output logic                  busy_o,

  // data bus
  output logic                  data_req_o,
  output lsu_bus_req_t          data_bus_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [lsu_data_w-1:0] data_rdata_i,

  // WB side
  output logic [lsu_data_w-1:0] rdata_o    // valid with data_rvalid_i
);

  lsu_bus_req_t bus_req;    // formed request, EX stage
  lsu_wb_ctrl_t wb_ctrl;    // lane and fill control for WB
  logic         ctrl_load;  // load granted, WB captures wb_ctrl

  ////////////////////////////////////////
  // EX: address, lanes, store data
  ////////////////////////////////////////

  lsu_req_format u_req_format (
    .ex_req_i  (ex_req_i),
    .bus_req_o (bus_req),
    .wb_ctrl_o (wb_ctrl)
  );

  ////////////////////////////////////////
  // bus issue and stall
  ////////////////////////////////////////

  lsu_bus_issue u_bus_issue (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_i),
    .bus_req_i      (bus_req),
    .data_req_o     (data_req_o),
    .data_bus_o     (data_bus_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .ctrl_load_o    (ctrl_load),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  ////////////////////////////////////////
  // WB: load alignment
  ////////////////////////////////////////

  lsu_resp_align u_resp_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_load_i  (ctrl_load),
    .wb_ctrl_i    (wb_ctrl),   // straight from the format stage
    .data_rdata_i (data_rdata_i),
    .rdata_o      (rdata_o)
  );

endmodule

// File: hw/lsu_resp_align.sv
`timescale 1ns/1ps

module lsu_resp_align import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ctrl_load_i,   // load granted this cycle
  input  lsu_wb_ctrl_t          wb_ctrl_i,     // control of the access on the bus
  input  logic [lsu_data_w-1:0] data_rdata_i,
  output logic [lsu_data_w-1:0] rdata_o        // aligned and extended load result
);

  lsu_wb_ctrl_t ctrl_q;  // control of the load waiting for rvalid
  logic [15:0]  half;    // selected halfword lane
  logic [7:0]   byte_l;  // selected byte lane
  logic [31:0]  half_ext;
  logic [31:0]  byte_ext;

  ////////////////////////////////////////
  // WB control register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '{dtype: LSU_WORD, ext: LSU_EXT_ZERO, offset: 2'b00};
    end else if (ctrl_load_i) begin
      ctrl_q <= wb_ctrl_i;  // held until the next granted load
    end
  end

  ////////////////////////////////////////
  // lane select
  ////////////////////////////////////////

  assign half = ctrl_q.offset[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];  // aligned halves

  always_comb begin
    case (ctrl_q.offset)
      2'b00:   byte_l = data_rdata_i[7:0];
      2'b01:   byte_l = data_rdata_i[15:8];
      2'b10:   byte_l = data_rdata_i[23:16];
      default: byte_l = data_rdata_i[31:24];
    endcase
  end

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////

  always_comb begin
    case (ctrl_q.ext)
      LSU_EXT_ZERO: half_ext = {16'h0000, half};
      LSU_EXT_ONES: half_ext = {16'hffff, half};
      default:      half_ext = {{16{half[15]}}, half};  // sign, also the spare code
    endcase
  end

  always_comb begin
    case (ctrl_q.ext)
      LSU_EXT_ZERO: byte_ext = {24'h00_0000, byte_l};
      LSU_EXT_ONES: byte_ext = {24'hff_ffff, byte_l};
      default:      byte_ext = {{24{byte_l[7]}}, byte_l};
    endcase
  end

  // word loads need no shifting since they are always aligned
  always_comb begin
    case (ctrl_q.dtype)
      LSU_WORD: rdata_o = data_rdata_i;
      LSU_HALF: rdata_o = half_ext;
      default:  rdata_o = byte_ext;
    endcase
  end

endmodule

// File: hw/lsu_bus_issue.sv
`timescale 1ns/1ps

module lsu_bus_issue import lsu_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         ex_valid_i,      // EX holds a valid access
  input  lsu_bus_req_t bus_req_i,       // formed address phase
  output logic         data_req_o,
  output lsu_bus_req_t data_bus_o,
  input  logic         data_gnt_i,
  input  logic         data_rvalid_i,
  output logic         ctrl_load_o,     // pulse per granted load
  output logic         lsu_ready_ex_o,
  output logic         lsu_ready_wb_o,
  output logic         busy_o
);

  logic outst_q;   // one transfer waits for its response
  logic issue_ok;  // issue rule met this cycle
  logic accepted;  // address phase completes

  ////////////////////////////////////////
  // request gating
  ////////////////////////////////////////

  // only one transfer in flight, a new one may go out in the cycle the
  // pending response lands
  assign issue_ok   = ~outst_q | data_rvalid_i;
  assign data_req_o = ex_valid_i & issue_ok;
  assign data_bus_o = bus_req_i;  // EX keeps fields stable until accepted
  assign accepted   = data_req_o & data_gnt_i;

  assign ctrl_load_o = accepted & ~bus_req_i.we;  // WB only tracks loads

  ////////////////////////////////////////
  // outstanding flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= 1'b0;
    end else if (accepted) begin
      outst_q <= 1'b1;          // grant wins over a same-cycle response
    end else if (data_rvalid_i) begin
      outst_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // stall signals
  ////////////////////////////////////////

  // EX moves on once its access is granted, with WB busy it also needs the
  // response so both stages advance together
  always_comb begin
    if (!ex_valid_i) begin
      lsu_ready_ex_o = 1'b1;
    end else if (!outst_q) begin
      lsu_ready_ex_o = data_gnt_i;
    end else begin
      lsu_ready_ex_o = data_gnt_i & data_rvalid_i;
    end
  end

  assign lsu_ready_wb_o = outst_q ? data_rvalid_i : 1'b1;  // idle WB never stalls

  assign busy_o = outst_q | data_req_o;  // in flight or asking

endmodule

// File: hw/lsu_req_format.sv
`timescale 1ns/1ps

module lsu_req_format import lsu_pkg::*; (
  input  lsu_ex_req_t  ex_req_i,   // access from EX
  output lsu_bus_req_t bus_req_o,  // formed address phase
  output lsu_wb_ctrl_t wb_ctrl_o   // control handed to WB
);

  logic [lsu_data_w-1:0] addr;       // effective address
  logic [1:0]            wdata_rot;  // byte rotation for store data
  logic [lsu_be_w-1:0]   be;
  logic [lsu_data_w-1:0] wdata;

  ////////////////////////////////////////
  // address
  ////////////////////////////////////////

  assign addr = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  // accesses are naturally aligned, so a half only sits at offset 0 or 2
  always_comb begin
    case (ex_req_i.dtype)
      LSU_WORD: be = 4'b1111;
      LSU_HALF: be = addr[1] ? 4'b1100 : 4'b0011;  // upper or lower lane pair
      default: begin  // byte
        case (addr[1:0])
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0010;
          2'b10:   be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
    endcase
  end

  ////////////////////////////////////////
  // store data lanes
  ////////////////////////////////////////

  // move the register byte at reg_offset onto the lane at addr[1:0]
  assign wdata_rot = addr[1:0] - ex_req_i.reg_offset;  // wraps mod 4

  always_comb begin
    case (wdata_rot)  // rotate left by whole bytes
      2'b00:   wdata = ex_req_i.wdata;
      2'b01:   wdata = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  always_comb begin
    bus_req_o.addr  = addr;
    bus_req_o.we    = ex_req_i.we;
    bus_req_o.be    = be;     // loads carry the lanes too, memory may ignore them
    bus_req_o.wdata = wdata;
  end

  always_comb begin
    wb_ctrl_o.dtype  = ex_req_i.dtype;
    wb_ctrl_o.ext    = ex_req_i.ext;
    wb_ctrl_o.offset = addr[1:0];  // lane select for the load
  end

endmodule

// File: hw/lsu_pkg.sv
package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned lsu_data_w = 32;              // data and address bus width
  localparam int unsigned lsu_be_w   = lsu_data_w / 8;  // byte lanes on the bus

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // access size, byte codes share the top half like the core decoder
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_dtype_e;

  // fill mode above the loaded lane
  typedef enum logic [1:0] {
    LSU_EXT_ZERO = 2'b00,  // zero fill
    LSU_EXT_SIGN = 2'b01,  // copy top bit of the lane
    LSU_EXT_ONES = 2'b10   // ones fill
  } lsu_ext_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // address phase of the data bus
  typedef struct packed {
    logic [lsu_data_w-1:0] addr;
    logic                  we;     // 1 = store
    logic [lsu_be_w-1:0]   be;
    logic [lsu_data_w-1:0] wdata;  // already rotated into its lanes
  } lsu_bus_req_t;

  // what WB needs to pick and extend the read lane
  typedef struct packed {
    lsu_dtype_e dtype;
    lsu_ext_e   ext;
    logic [1:0] offset;  // addr[1:0] of the access
  } lsu_wb_ctrl_t;

  // one access as presented by EX
  typedef struct packed {
    logic [lsu_data_w-1:0] op_a;
    logic [lsu_data_w-1:0] op_b;
    logic                  use_incr;    // addr = op_a + op_b
    logic                  we;
    lsu_dtype_e            dtype;
    lsu_ext_e              ext;
    logic [lsu_data_w-1:0] wdata;       // store data as held in the register
    logic [1:0]            reg_offset;  // byte position of the data inside the register
  } lsu_ex_req_t;

endpackage
